// ==== src/burst_write_pkg.sv ====
// shared bus geometry and types; burstcount is sized for bursts of up to max_burst_limit words
`default_nettype none

package burst_write_pkg;

	// bus geometry, every beat is one full 32-bit word
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int bytes_per_word = 4; // also the byteenable width

	// the largest burst any master built on this package may post
	localparam int max_burst_limit = 8;
	localparam int burst_count_width = $clog2(max_burst_limit) + 1; // 4 bits, holds 8

	// one transfer request as the command side hands it in
	typedef struct packed {
		logic [addr_width-1:0] base; // word aligned byte address
		logic [addr_width-1:0] length; // bytes, a multiple of bytes_per_word
		logic fixed_location; // every beat goes to base
	} write_cmd_t;

	// write side of the burst bus, address and burstcount hold for a whole burst
	typedef struct packed {
		logic [addr_width-1:0] address;
		logic write;
		logic [bytes_per_word-1:0] byteenable;
		logic [data_width-1:0] writedata;
		logic [burst_count_width-1:0] burstcount;
	} bus_write_t;

	// command sequencing states of transfer_control
	// idle waits for a command, launch pulses go, run waits for the master to drain the length
	// and finish pulses done for one cycle
	typedef enum logic [1:0] {
		idle = 2'd0,
		launch = 2'd1,
		run = 2'd2,
		finish = 2'd3
	} xfer_state_t;

endpackage

`default_nettype wire

// ==== src/showahead_fifo.sv ====
// depth must be a power of two; no overflow or underflow protection, the user keeps push and pop legal
`timescale 1ns/100ps
`default_nettype none

module showahead_fifo
	import burst_write_pkg::*;
#(
	parameter int depth = 32,
	localparam int depth_log2 = $clog2(depth)
)
(
	input wire clk,
	input wire reset,
	input wire push, // writes push_data at the tail
	input wire [data_width-1:0] push_data,
	input wire pop, // drops the head word
	output logic [data_width-1:0] head_data, // head word, valid whenever used is non-zero
	output logic [depth_log2:0] used, // one extra bit so a full buffer reads as depth
	output logic almost_full
);

	// storage has no reset, only the pointers and the count define what is valid
	logic [data_width-1:0] mem [depth];

	logic [depth_log2-1:0] wr_ptr; // next slot to be written
	logic [depth_log2-1:0] rd_ptr; // slot currently shown at the head

	// write port, pointers wrap naturally since depth is a power of two
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// the count moves one edge after the push or pop that changed it
	// a push and pop in the same cycle leave it where it was
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			used <= '0;
		end
		else
		begin
			case ({push, pop})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

	// show-ahead read, the head is out of the array with no register in between
	assign head_data = mem[rd_ptr];

	// two words of slack so a feeder that looks at this flag one cycle late still fits
	assign almost_full = (used >= (depth_log2 + 1)'(depth - 2));

endmodule

`default_nettype wire

// ==== src/burst_write_master.sv ====
// max_burst is a power of two up to 8 and fifo_depth a power of two of at least 2*max_burst; fixed_location suits burstcount 1 targets
`timescale 1ns/100ps
`default_nettype none

module burst_write_master
	import burst_write_pkg::*;
#(
	parameter int max_burst = 4, // words in a full burst
	parameter int fifo_depth = 32 // words in the user buffer
)
(
	input wire clk,
	input wire reset,
	input wire go, // one-cycle pulse, loads start_cmd
	input wire write_cmd_t start_cmd, // held stable by the command block for the whole transfer
	input wire user_write,
	input wire [data_width-1:0] user_data,
	input wire waitrequest,
	output logic length_zero, // nothing left to write
	output logic user_full,
	output bus_write_t bus
);

	localparam int fifo_depth_log2 = $clog2(fifo_depth);
	localparam int burst_bytes = max_burst * bytes_per_word; // span of one burst boundary window
	localparam logic [burst_count_width-1:0] max_count = burst_count_width'(max_burst);

	logic [addr_width-1:0] address; // burst start address, held for the whole burst
	logic [addr_width-1:0] length; // bytes still to be written
	logic [addr_width-1:0] length_words;
	logic [burst_count_width-1:0] burstcount; // count of the burst being posted
	logic [burst_count_width-1:0] beat_counter; // beats still owed in the current burst
	logic first_transfer; // no burst posted yet since go

	logic [fifo_depth_log2:0] fifo_used;
	logic [data_width-1:0] head_data;

	logic [burst_count_width-1:0] boundary_offset; // word offset of address inside its window
	logic [burst_count_width-1:0] first_short_count;
	logic [burst_count_width-1:0] final_short_count;
	logic [burst_count_width-1:0] next_count; // length of the burst that starts on burst_begin
	logic first_short_enable;
	logic first_short_ready;
	logic final_short_enable;
	logic final_short_ready;
	logic full_ready;
	logic burst_begin;
	logic beat_accept; // write high and waitrequest low
	logic write;

	assign length_words = length / bytes_per_word;
	assign boundary_offset = burst_count_width'((address / bytes_per_word) & (max_burst - 1));

	// realignment only applies to the very first burst of a transfer
	assign first_short_enable = (boundary_offset != '0) && first_transfer;

	// an odd offset needs a single word to reach an even one, otherwise fill the window,
	// unless the whole transfer ends inside it
	always_comb
	begin
		if (boundary_offset[0])
		begin
			first_short_count = burst_count_width'(1);
		end
		else if ((max_count - boundary_offset) < length_words)
		begin
			first_short_count = max_count - boundary_offset;
		end
		else
		begin
			first_short_count = final_short_count;
		end
	end

	// the tail of the transfer, less than one full burst left
	assign final_short_enable = (length < burst_bytes);
	assign final_short_count = burst_count_width'(length_words); // only meaningful while enabled

	// fifo_used lags a pop by one edge, so an exact match only counts once the
	// previous burst has fully drained
	assign first_short_ready = (fifo_used > first_short_count) ||
		((fifo_used == first_short_count) && (beat_counter == '0));
	assign final_short_ready = (fifo_used > final_short_count) ||
		((fifo_used == final_short_count) && (beat_counter == '0));
	assign full_ready = (fifo_used > max_count) ||
		((fifo_used == max_count) && (beat_counter == '0));

	// a new burst starts when idle, or on the last accepted beat of a burst as long as
	// what follows is another full burst
	assign burst_begin = ((first_short_enable && first_short_ready) ||
		(final_short_enable && final_short_ready) || full_ready) &&
		!length_zero &&
		((beat_counter == '0) ||
		((beat_counter == burst_count_width'(1)) && !waitrequest && (length > burst_bytes)));

	// realignment wins over the tail, which covers a short unaligned transfer too
	assign next_count = first_short_enable ? first_short_count :
		final_short_enable ? final_short_count : max_count;

	assign length_zero = (length == '0);
	assign write = !length_zero && (beat_counter != '0);
	assign beat_accept = write && !waitrequest;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			first_transfer <= 1'b0;
		end
		else if (go)
		begin
			first_transfer <= 1'b1;
		end
		else if (burst_begin)
		begin
			first_transfer <= 1'b0;
		end
	end

	// the first burst goes to base itself, later ones step past the previous burst
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			address <= '0;
		end
		else if (go)
		begin
			address <= start_cmd.base;
		end
		else if (!first_transfer && burst_begin && !start_cmd.fixed_location)
		begin
			address <= address + addr_width'(burstcount * bytes_per_word);
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			length <= '0;
		end
		else if (go)
		begin
			length <= start_cmd.length;
		end
		else if (beat_accept)
		begin
			length <= length - addr_width'(bytes_per_word); // one full word per beat
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			burstcount <= '0;
		end
		else if (burst_begin)
		begin
			burstcount <= next_count;
		end
	end

	// counts the beats of a burst down, a zero here stalls the bus until the buffer
	// holds enough words for the next burst
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			beat_counter <= '0;
		end
		else if (go)
		begin
			beat_counter <= '0;
		end
		else if (burst_begin)
		begin
			beat_counter <= next_count; // also covers the back-to-back reload on the last beat
		end
		else if (beat_accept)
		begin
			beat_counter <= beat_counter - 1'b1;
		end
	end

	// user words wait here until a burst has room for them
	showahead_fifo #(
		.depth(fifo_depth)
	) i_fifo (
		.clk(clk),
		.reset(reset),
		.push(user_write),
		.push_data(user_data),
		.pop(beat_accept), // the head word goes out with each accepted beat
		.head_data(head_data),
		.used(fifo_used),
		.almost_full(user_full)
	);

	always_comb
	begin
		bus.address = address;
		bus.write = write;
		bus.byteenable = '1; // word accesses only
		bus.writedata = head_data;
		bus.burstcount = burstcount;
	end

endmodule

`default_nettype wire

// ==== src/transfer_control.sv ====
// one command at a time; a cmd_valid while busy is dropped, not queued
`timescale 1ns/100ps
`default_nettype none

module transfer_control
	import burst_write_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire cmd_valid, // one-cycle command strobe
	input wire write_cmd_t cmd,
	input wire length_zero, // from the master, remaining length is zero
	output logic go,
	output write_cmd_t start_cmd, // held for the master until the next accepted command
	output logic busy,
	output logic done
);

	xfer_state_t state;
	xfer_state_t next_state;
	logic accept;

	// commands are taken when idle, and also in the done cycle since busy is already low there
	assign accept = cmd_valid && ((state == idle) || (state == finish));

	always_comb
	begin
		next_state = state;
		case (state)
			idle: if (accept) next_state = launch;
			launch: next_state = run; // go goes out this cycle, the master loads on the edge
			run: if (length_zero) next_state = finish; // length is valid again here
			finish: next_state = accept ? launch : idle;
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
		end
		else
		begin
			state <= next_state;
		end
	end

	// command payload, only meaningful once a command has been accepted
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			start_cmd <= cmd;
		end
	end

	assign go = (state == launch);
	assign busy = (state == launch) || (state == run);
	assign done = (state == finish); // busy is already low in this cycle

endmodule

`default_nettype wire

// ==== src/burst_write_top.sv ====
// user must not push while user_full is high; fifo_depth is a power of two of at least 2*max_burst
`timescale 1ns/100ps
`default_nettype none

module burst_write_top
	import burst_write_pkg::*;
#(
	parameter int max_burst = 4, // words per full burst, a power of two up to 8
	parameter int fifo_depth = 32 // user buffer words
)
(
	input wire clk,
	input wire reset,

	// command side
	input wire cmd_valid,
	input wire write_cmd_t cmd,
	output logic busy,
	output logic done,

	// user stream side
	input wire user_write,
	input wire [data_width-1:0] user_data,
	output logic user_full, // almost full, raised at fifo_depth minus 2 words

	// burst bus side
	output bus_write_t bus,
	input wire waitrequest
);

	logic go;
	logic length_zero;
	write_cmd_t start_cmd;

	// command front end, keeps a transfer from being restarted halfway
	transfer_control i_control (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.length_zero(length_zero),
		.go(go),
		.start_cmd(start_cmd),
		.busy(busy),
		.done(done)
	);

	// burst engine with its own user buffer
	burst_write_master #(
		.max_burst(max_burst),
		.fifo_depth(fifo_depth)
	) i_master (
		.clk(clk),
		.reset(reset),
		.go(go),
		.start_cmd(start_cmd),
		.user_write(user_write),
		.user_data(user_data),
		.waitrequest(waitrequest),
		.length_zero(length_zero),
		.user_full(user_full),
		.bus(bus)
	);

endmodule

`default_nettype wire

// ==== test/burst_write_checker.sv ====
// follows one command at a time; the testbench frames each test with test_start and test_end pulses
`timescale 1ns/100ps
`default_nettype none

module burst_write_checker
	import burst_write_pkg::*;
#(
	parameter int max_burst = 4, // has to match the DUT
	parameter int fifo_depth = 32 // has to match the DUT, sets the almost-full level
)
(
	input wire clk,
	input wire reset,
	input wire bus_write_t bus,
	input wire waitrequest,
	input wire busy,
	input wire done,
	input wire user_write,
	input wire user_full,
	input wire test_start, // one cycle, together with the command strobe
	input wire test_end, // one cycle, a few cycles after done
	input wire [127:0] test_name,
	input wire write_cmd_t exp_cmd,
	input wire [data_width-1:0] exp_data_start, // word n of the test carries this plus n
	output int error_count
);

	localparam int burst_bytes = max_burst * bytes_per_word;

	write_cmd_t cmd_q;
	logic [data_width-1:0] data_start_q;
	logic [127:0] name_q;
	int total_words;
	int beat_index; // beats accepted so far in this test
	int burst_index;
	int beats_left; // beats still owed by the burst on the bus
	int done_count;
	int words_held; // words in the user buffer as of the last edge
	logic active;
	logic transfer_open; // a command went in and its done pulse has not come yet
	logic window_aligned; // the first burst ended on a window boundary
	logic [addr_width-1:0] burst_addr;
	logic [burst_count_width-1:0] burst_cnt;
	bus_write_t stalled_bus; // bus as it was in a cycle held by waitrequest
	logic stalled;

	initial
	begin
		error_count = 0;
	end

	// an odd word offset takes one word first, an even one fills up its window,
	// later bursts are full until the tail
	function automatic int expected_count(input int remaining, input int word_offset,
		input logic first_burst);
		int count;
		if (first_burst && (word_offset != 0))
		begin
			count = (word_offset % 2 != 0) ? 1 : max_burst - word_offset;
		end
		else
		begin
			count = max_burst;
		end
		if (count > remaining)
		begin
			count = remaining; // never more than what is left
		end
		return count;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("error: test %0s, %0s expected 0x%08h actual 0x%08h",
				name_q, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("failure in test %0s: %0s", name_q, what);
		error_count++;
	endtask

	task automatic check_beat();
		int count;
		int word_offset;
		word_offset = int'((cmd_q.base / bytes_per_word) % max_burst);
		if (!active)
		begin
			report_failure("bus write with no command in progress");
		end
		else if (beat_index >= total_words)
		begin
			report_failure("extra beat past the command length");
		end
		else
		begin
			if (beats_left == 0) // first beat of a new burst
			begin
				count = expected_count(total_words - beat_index, word_offset, burst_index == 0);
				check_value("burstcount", 32'(count), 32'(bus.burstcount));
				check_value("burst address", cmd_q.fixed_location ? cmd_q.base :
					cmd_q.base + 32'(beat_index * bytes_per_word), bus.address);
				if (window_aligned && !cmd_q.fixed_location && (burst_index > 0) &&
					((bus.address % burst_bytes) != 0))
				begin
					report_failure("burst after realignment starts off a window boundary");
				end
				if (burst_index == 0)
				begin
					window_aligned = (((cmd_q.base / bytes_per_word) + 32'(bus.burstcount))
						% max_burst) == 0;
				end
				burst_addr = bus.address;
				burst_cnt = bus.burstcount;
				beats_left = int'(bus.burstcount);
				burst_index++;
			end
			else
			begin
				check_value("address inside burst", burst_addr, bus.address);
				check_value("burstcount inside burst", 32'(burst_cnt), 32'(bus.burstcount));
			end
			check_value("writedata", data_start_q + 32'(beat_index), bus.writedata); // in order
			check_value("byteenable", 32'hf, 32'(bus.byteenable));
			beat_index++;
			beats_left--;
		end
	endtask

	// everything is sampled on the rising edge, the testbench only drives on the falling one
	always @(posedge clk)
	begin
		if (reset)
		begin
			if (bus.write || busy || done || user_full)
			begin
				report_failure("outputs not idle while reset is high");
			end
			active = 1'b0;
			stalled = 1'b0;
			transfer_open = 1'b0;
			words_held = 0;
		end
		else
		begin
			// busy has to stay up from the edge after the command until the done cycle
			if (transfer_open && !done && !busy)
			begin
				report_failure("busy low while a command was still in progress");
			end
			if (test_start)
			begin
				cmd_q = exp_cmd;
				data_start_q = exp_data_start;
				name_q = test_name;
				total_words = int'(exp_cmd.length / bytes_per_word);
				beat_index = 0;
				burst_index = 0;
				beats_left = 0;
				done_count = 0;
				window_aligned = 1'b0;
				active = 1'b1;
				transfer_open = 1'b1;
			end
			if (stalled && (bus !== stalled_bus))
			begin
				report_failure("bus changed while waitrequest held a beat");
			end
			stalled = bus.write && waitrequest;
			stalled_bus = bus;
			if (bus.write && !waitrequest)
			begin
				check_beat();
			end
			if (done)
			begin
				transfer_open = 1'b0;
				if (!active)
				begin
					report_failure("done pulse with no command in progress");
				end
				else
				begin
					done_count++;
					check_value("beats at done", 32'(total_words), 32'(beat_index));
					if (busy)
					begin
						report_failure("busy still high in the done cycle");
					end
				end
			end
			if (user_write && user_full)
			begin
				report_failure("user data pushed while user_full was high");
			end
			// the flag follows the word count of the previous edge, two words short of full
			check_value("user_full", 32'(words_held >= (fifo_depth - 2)), 32'(user_full));
			if (user_write)
			begin
				words_held++;
			end
			if (bus.write && !waitrequest)
			begin
				words_held--; // each accepted beat takes the head word
			end
			if (test_end)
			begin
				check_value("done pulses", 32'd1, 32'(done_count)); // one per accepted command
				check_value("beats", 32'(total_words), 32'(beat_index));
				if (busy)
				begin
					report_failure("busy high after done");
				end
				active = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_burst_write.sv ====
// feeds exactly length/4 words per test and never pushes while user_full is high; seed 34251
`timescale 1ns/100ps
`default_nettype none

module tb_burst_write;
	import burst_write_pkg::*;

	localparam int max_burst = 4;
	localparam int fifo_depth = 32;
	localparam int idle_limit = 200; // cycles to wait for busy to drop
	localparam int done_limit = 5000; // cycles to wait for done per test

	typedef struct packed {
		logic [127:0] name;
		logic [31:0] base;
		logic [31:0] length; // bytes
		logic fixed_location;
		int unsigned wait_pct; // chance of waitrequest in a cycle, percent
		int unsigned push_pct; // chance of a user push in a cycle, percent
		logic second_cmd; // a second command is sent while busy
		logic [31:0] data_start;
	} test_row_t;

	localparam int num_rows = 11;
	localparam test_row_t rows [num_rows] = '{
		'{"aligned_bursts", 32'h0000_1000, 32'd64, 1'b0, 0, 100, 1'b0, 32'h0100_0000},
		'{"offset_one", 32'h0000_2004, 32'd40, 1'b0, 10, 90, 1'b0, 32'h0200_0000},
		'{"offset_three", 32'h0000_300c, 32'd36, 1'b0, 10, 90, 1'b0, 32'h0300_0000},
		'{"offset_two", 32'h0000_4008, 32'd44, 1'b0, 10, 90, 1'b0, 32'h0400_0000},
		'{"offset_two_tiny", 32'h0000_5008, 32'd4, 1'b0, 0, 100, 1'b0, 32'h0500_0000},
		'{"short_tail", 32'h0000_6000, 32'd28, 1'b0, 0, 100, 1'b0, 32'h0600_0000},
		'{"fixed_unaligned", 32'h0000_7004, 32'd32, 1'b1, 20, 80, 1'b0, 32'h0700_0000},
		'{"backpressure", 32'h0000_8000, 32'd160, 1'b0, 40, 30, 1'b0, 32'h0800_0000},
		'{"second_command", 32'h0000_9008, 32'd48, 1'b0, 20, 70, 1'b1, 32'h0900_0000},
		'{"long_random", 32'h0000_a00c, 32'd200, 1'b0, 30, 50, 1'b0, 32'h0a00_0000},
		'{"fill_buffer", 32'h0000_b000, 32'd192, 1'b0, 90, 100, 1'b0, 32'h0b00_0000}
	};

	logic clk = 1'b0;
	logic reset;
	logic cmd_valid;
	write_cmd_t cmd;
	logic busy;
	logic done;
	logic user_write;
	logic [data_width-1:0] user_data;
	logic user_full;
	bus_write_t bus;
	logic waitrequest;
	logic test_start;
	logic test_end;
	logic [127:0] test_name;
	write_cmd_t exp_cmd;
	logic [data_width-1:0] exp_data_start;
	int error_count;
	int timeout_count;
	logic row_ok;

	always #50 clk = ~clk; // 100 ns period

	burst_write_top #(
		.max_burst(max_burst),
		.fifo_depth(fifo_depth)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.done(done),
		.user_write(user_write),
		.user_data(user_data),
		.user_full(user_full),
		.bus(bus),
		.waitrequest(waitrequest)
	);

	burst_write_checker #(
		.max_burst(max_burst),
		.fifo_depth(fifo_depth)
	) i_checker (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.waitrequest(waitrequest),
		.busy(busy),
		.done(done),
		.user_write(user_write),
		.user_full(user_full),
		.test_start(test_start),
		.test_end(test_end),
		.test_name(test_name),
		.exp_cmd(exp_cmd),
		.exp_data_start(exp_data_start),
		.error_count(error_count)
	);

	// one row: command, feeder and random waitrequest all advance on the falling edge
	task automatic run_row(input test_row_t row, output logic finished);
		int cycle;
		int pushed;
		int total_words;
		logic seen_done;
		finished = 1'b0;
		total_words = int'(row.length / bytes_per_word);
		pushed = 0;
		seen_done = 1'b0;
		cycle = 0;
		while (busy && (cycle < idle_limit))
		begin
			@(negedge clk);
			cycle++;
		end
		if (busy)
		begin
			$display("timeout: DUT still busy before test %0s could start", row.name);
			timeout_count++;
		end
		else
		begin
			test_name = row.name;
			exp_cmd = '{row.base, row.length, row.fixed_location};
			exp_data_start = row.data_start;
			cycle = 0;
			while (!seen_done && (cycle < done_limit))
			begin
				@(negedge clk);
				seen_done = done; // done is a one-cycle level, stable around the falling edge
				test_start = (cycle == 0);
				if (cycle == 0)
				begin
					cmd_valid = 1'b1;
					cmd = '{row.base, row.length, row.fixed_location};
				end
				else if (row.second_cmd && (cycle == 3) && busy && !seen_done)
				begin
					cmd_valid = 1'b1; // the command block has to drop this one
					cmd = '{row.base + 32'h100, 32'd8, 1'b0};
				end
				else
				begin
					cmd_valid = 1'b0;
				end
				user_write = !seen_done && (pushed < total_words) && !user_full &&
					($urandom_range(99) < row.push_pct);
				if (user_write)
				begin
					user_data = row.data_start + 32'(pushed); // sequential words
					pushed++;
				end
				waitrequest = !seen_done && ($urandom_range(99) < row.wait_pct);
				cycle++;
			end
			if (!seen_done)
			begin
				$display("timeout: test %0s got no done pulse within %0d cycles", row.name,
					done_limit);
				timeout_count++;
			end
			else
			begin
				repeat (2) @(negedge clk); // room for any stray beat to show up
				test_end = 1'b1;
				@(negedge clk);
				test_end = 1'b0;
				finished = 1'b1;
			end
		end
	endtask

	initial
	begin
		void'($urandom(34251));
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		user_write = 1'b0;
		user_data = '0;
		waitrequest = 1'b0;
		test_start = 1'b0;
		test_end = 1'b0;
		test_name = '0;
		exp_cmd = '0;
		exp_data_start = '0;
		timeout_count = 0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		for (int r = 0; r < num_rows; r++)
		begin
			run_row(rows[r], row_ok);
			if (!row_ok)
			begin
				break; // a stuck DUT would only pile up more timeouts
			end
		end
		$display("closing: %0d errors, %0d timeouts", error_count, timeout_count);
		if ((error_count == 0) && (timeout_count == 0))
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/burst_write_pkg.sv
src/showahead_fifo.sv
src/burst_write_master.sv
src/transfer_control.sv
src/burst_write_top.sv
test/burst_write_checker.sv
test/tb_burst_write.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it into sim.log and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -Wno-fatal \
	--top-module tb_burst_write \
	-f verilog.f \
	-o tb_burst_write
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_burst_write > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with a failing status, see sim.log"
	exit 1
fi

grep -q "Simulation PASSED" sim.log
if [ $? -ne 0 ]; then
	echo "no pass line in sim.log, the run failed"
	exit 1
fi

echo "run passed, log in sim.log"
exit 0
